// ==== filelist.f ====
+incdir+include
hw/acc_read_pkg.sv
hw/acc_infifo.sv
hw/acc_read_ctrl.sv
hw/acc_add_counter.sv
hw/acc_delay_line.sv
hw/acc_read_top.sv
verif/tb_acc_read.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_acc_read
RTL_TOP    := acc_read_top
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/tb_acc_read_ref.svh ====
`ifndef TB_ACC_READ_REF_SVH
`define TB_ACC_READ_REF_SVH

// ====================
// Stimulus LFSR
// ====================
// 16-bit Galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// ====================
// Reference model
// ====================
// Poly id runs fastest inside a ciphertext
function automatic int poly_of(input int word_idx);
  return word_idx % GLWE_K_P1;
endfunction

function automatic int stage_of(input int word_idx);
  return word_idx / GLWE_K_P1;
endfunction

// GRAM address of one word of the ciphertext in slot grof
function automatic logic [ADD_W-1:0] word_addr(input int grof, input int word_idx);
  int full_add;
  full_add = grof * CT_WORDS + poly_of(word_idx) * STG_ITER_NB + stage_of(word_idx);
  return ADD_W'(full_add);
endfunction

// Mask polys of a first command read back as zero
function automatic logic mask_null_of(input logic first, input int word_idx);
  return first && (poly_of(word_idx) < GLWE_K);
endfunction

// Packed as {feed_done, sxt_avail, br_loop_done, map_idx}
function automatic logic [MAP_IDX_W+2:0] done_flags(
  input logic                 last,
  input logic                 batch_last,
  input logic [MAP_IDX_W-1:0] map_idx
);
  return {~last, last, batch_last, map_idx};
endfunction

`endif

// ==== verif/tb_acc_read.sv ====
`default_nettype none

module tb_acc_read;

  localparam int DATA_W       = acc_read_pkg::DEF_DATA_W;
  localparam int GLWE_K       = acc_read_pkg::DEF_GLWE_K;
  localparam int GLWE_K_P1    = GLWE_K + 1;
  localparam int STG_ITER_NB  = acc_read_pkg::DEF_STG_ITER_NB;
  localparam int GRAM_NB      = acc_read_pkg::DEF_GRAM_NB;
  localparam int FIFO_DEPTH   = acc_read_pkg::DEF_FIFO_DEPTH;
  localparam int DATA_LATENCY = acc_read_pkg::DEF_DATA_LATENCY;
  localparam int ADD_W        = 8;
  localparam int MAP_IDX_W    = 4;
  localparam int CT_WORDS     = GLWE_K_P1 * STG_ITER_NB;
  localparam int SR_DEPTH     = DATA_LATENCY + 2;
  localparam int GRID_W       = $clog2(GRAM_NB);
  localparam int GROF_W       = $clog2((2 ** ADD_W) / CT_WORDS);
  localparam int FIFO_CT      = FIFO_DEPTH / CT_WORDS;
  localparam int NB_STREAM    = 12;
  localparam int TIMEOUT_CYC  = (NB_STREAM + FIFO_CT) * (CT_WORDS + 20) + 200;

  typedef struct packed {
    logic [GRID_W-1:0]    grid;
    logic [GROF_W-1:0]    grof;
    logic                 first;
    logic                 last;
    logic                 batch_last;
    logic [MAP_IDX_W-1:0] map_idx;
  } cmd_t;

  logic clk, s_rst_n;
  logic ntt_acc_avail, ntt_acc_sog, ntt_acc_eog;
  logic [DATA_W-1:0] ntt_acc_data;
  logic cmd_vld, cmd_rdy, cmd_first, cmd_last, cmd_batch_last;
  logic [GRID_W-1:0] cmd_grid, garb_req_grid, rd_grid, s1_grid;
  logic [GROF_W-1:0] cmd_grof;
  logic [MAP_IDX_W-1:0] cmd_map_idx, feed_done_map_idx, sxt_map_idx;
  logic garb_req_vld, garb_req_rdy, garb_req_critical;
  logic [GRAM_NB-1:0] garb_rd_avail_1h;
  logic rd_en, s0_mask_null, s1_avail, feed_done, br_loop_done, sxt_avail, error;
  logic [ADD_W-1:0] rd_add, s1_add;
  logic [DATA_W-1:0] s1_data;

  `include "tb_acc_read_ref.svh"

  // Scoreboard state
  logic [15:0]          data_lfsr;
  logic [GRID_W-1:0]    act_grid;
  logic [DATA_W-1:0]    word_q[$];
  cmd_t                 cmd_q[$];
  int                   due_q[$];
  logic [ADD_W-1:0]     add_q[$];
  logic [GRID_W-1:0]    grid_q[$];
  logic [DATA_W-1:0]    data_q[$];
  logic                 mask_exp[int];
  logic [MAP_IDX_W+2:0] flag_exp[int];
  int cycle = 0;
  int word_idx = 0;
  int err_pulses = 0;
  int n_checks = 0;
  int n_errors = 0;

  acc_read_top u_acc_read_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error @ %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[30:0], data_lfsr[0]};
    end
    return v;
  endfunction

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("test %s: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
  endtask

  // ====================
  // Stimulus
  // ====================
  task automatic push_ct();
    logic [DATA_W-1:0] word;
    for (int w = 0; w < CT_WORDS; w++) begin
      word = DATA_W'(rand_bits(DATA_W));
      @(posedge clk);
      ntt_acc_avail <= 1'b1;
      ntt_acc_data  <= word;
      ntt_acc_sog   <= (w == 0);
      ntt_acc_eog   <= (w == CT_WORDS - 1);
      word_q.push_back(word);
    end
    @(posedge clk);
    ntt_acc_avail <= 1'b0;
  endtask

  task automatic send_cmd();
    cmd_t c;
    c.grid       = GRID_W'(rand_bits(GRID_W));
    c.grof       = GROF_W'(rand_bits(GROF_W));
    c.first      = rand_bits(1) != 0;
    c.last       = rand_bits(1) != 0;
    c.batch_last = rand_bits(1) != 0;
    c.map_idx    = MAP_IDX_W'(rand_bits(MAP_IDX_W));
    @(posedge clk);
    cmd_vld        <= 1'b1;
    cmd_grid       <= c.grid;
    cmd_grof       <= c.grof;
    cmd_first      <= c.first;
    cmd_last       <= c.last;
    cmd_batch_last <= c.batch_last;
    cmd_map_idx    <= c.map_idx;
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    cmd_q.push_back(c);
    act_grid = c.grid;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_drained();
    while (cmd_q.size() != 0 || due_q.size() != 0 || flag_exp.num() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  // Grant sits on the active bank 3 in 4 cycles and on its neighbour otherwise
  initial begin
    logic [15:0] gnt_lfsr;
    logic        b0;
    gnt_lfsr         = 16'd47;
    garb_rd_avail_1h = '0;
    forever begin
      @(posedge clk);
      gnt_lfsr = lfsr_next(gnt_lfsr);
      b0       = gnt_lfsr[0];
      gnt_lfsr = lfsr_next(gnt_lfsr);
      garb_rd_avail_1h <= (b0 | gnt_lfsr[0]) ? GRAM_NB'(1) << act_grid
                                            : GRAM_NB'(1) << GRID_W'(act_grid + 1'b1);
    end
  end

  // Arbiter accepts each request after 0 to 3 cycles
  initial begin
    logic [15:0] arb_lfsr;
    int          wait_cyc;
    arb_lfsr     = 16'd47;
    garb_req_rdy = 1'b0;
    forever begin
      @(negedge clk);
      if (s_rst_n && garb_req_vld) begin
        compare("garb_req_grid", garb_req_grid, act_grid);
        arb_lfsr = lfsr_next(arb_lfsr);
        wait_cyc = arb_lfsr[0];
        arb_lfsr = lfsr_next(arb_lfsr);
        wait_cyc = wait_cyc * 2 + arb_lfsr[0];
        repeat (wait_cyc) @(posedge clk);
        @(posedge clk);
        garb_req_rdy <= 1'b1;
        @(posedge clk);
        garb_req_rdy <= 1'b0;
      end
    end
  end

  // ====================
  // Comparison
  // ====================
  always @(negedge clk) begin : monitor
    cmd_t cur;
    cycle++;
    if (s_rst_n) begin
      if (error)
        err_pulses++;
      if (rd_en) begin
        if (cmd_q.size() == 0 || word_q.size() == 0) begin
          n_errors++;
          $display("read at %0t with no command or no buffered word", $time);
        end else begin
          cur = cmd_q[0];
          compare("rd_add", rd_add, word_addr(cur.grof, word_idx));
          compare("rd_grid", rd_grid, cur.grid);
          compare("grant bit at read", garb_rd_avail_1h[cur.grid], 1'b1);
          due_q.push_back(cycle + SR_DEPTH);
          add_q.push_back(word_addr(cur.grof, word_idx));
          grid_q.push_back(cur.grid);
          data_q.push_back(word_q.pop_front());
          mask_exp[cycle + SR_DEPTH - 1] = mask_null_of(cur.first, word_idx);
          if (word_idx == CT_WORDS - 1) begin
            flag_exp[cycle + SR_DEPTH + 1] = done_flags(cur.last, cur.batch_last, cur.map_idx);
            void'(cmd_q.pop_front());
            word_idx = 0;
          end else begin
            word_idx++;
          end
        end
      end
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        compare("s1_avail", s1_avail, 1'b1);
        compare("s1_add", s1_add, add_q.pop_front());
        compare("s1_grid", s1_grid, grid_q.pop_front());
        compare("s1_data", s1_data, data_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        compare("s1_avail", s1_avail, 1'b0);
      end
      if (mask_exp.exists(cycle)) begin
        compare("s0_mask_null", s0_mask_null, mask_exp[cycle]);
        mask_exp.delete(cycle);
      end
      if (flag_exp.exists(cycle)) begin
        compare("done flags", {feed_done, sxt_avail, br_loop_done},
                flag_exp[cycle][MAP_IDX_W+:3]);
        if (flag_exp[cycle][MAP_IDX_W+2])
          compare("feed_done_map_idx", feed_done_map_idx, flag_exp[cycle][MAP_IDX_W-1:0]);
        if (flag_exp[cycle][MAP_IDX_W+1])
          compare("sxt_map_idx", sxt_map_idx, flag_exp[cycle][MAP_IDX_W-1:0]);
        flag_exp.delete(cycle);
      end else begin
        compare("done flags", {feed_done, sxt_avail, br_loop_done}, 3'b000);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int chk0;
    int err0;
    data_lfsr      = 16'd47;
    act_grid       = '0;
    s_rst_n        = 1'b0;
    ntt_acc_avail  = 1'b0;
    ntt_acc_data   = '0;
    ntt_acc_sog    = 1'b0;
    ntt_acc_eog    = 1'b0;
    cmd_vld        = 1'b0;
    cmd_grid       = '0;
    cmd_grof       = '0;
    cmd_first      = 1'b0;
    cmd_last       = 1'b0;
    cmd_batch_last = 1'b0;
    cmd_map_idx    = '0;
    repeat (4) @(posedge clk);
    s_rst_n <= 1'b1;
    @(negedge clk);
    compare("outputs after reset", {cmd_rdy, garb_req_vld, rd_en, s1_avail, feed_done,
                                    sxt_avail, br_loop_done, error}, 8'h00);
    report_test("reset", 0, 0);

    // Push and read back one ciphertext at a time
    chk0 = n_checks;
    err0 = n_errors;
    for (int i = 0; i < NB_STREAM; i++) begin
      push_ct();
      if (i == 0) begin
        @(negedge clk);
        compare("garb_req_critical", garb_req_critical, 1'b0);
      end
      send_cmd();
    end
    wait_drained();
    compare("error pulses", err_pulses, 0);
    report_test("stream", chk0, err0);

    // Fill the FIFO and push one word too many
    chk0 = n_checks;
    err0 = n_errors;
    repeat (FIFO_CT) push_ct();
    repeat (3) @(negedge clk);
    compare("garb_req_critical", garb_req_critical, 1'b1);
    @(posedge clk);
    ntt_acc_avail <= 1'b1;
    ntt_acc_data  <= DATA_W'(rand_bits(DATA_W));
    ntt_acc_sog   <= 1'b0;
    ntt_acc_eog   <= 1'b0;
    @(posedge clk);
    ntt_acc_avail <= 1'b0;
    @(negedge clk);
    compare("error", error, 1'b1);
    @(negedge clk);
    compare("error", error, 1'b0);
    repeat (FIFO_CT) send_cmd();
    wait_drained();
    compare("error pulses", err_pulses, 1);
    report_test("critical_overflow", chk0, err0);

    $display("total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/acc_read_top.sv ====
`default_nettype none

module acc_read_top #(
  parameter int DATA_W       = acc_read_pkg::DEF_DATA_W,
  parameter int GLWE_K       = acc_read_pkg::DEF_GLWE_K,
  parameter int STG_ITER_NB  = acc_read_pkg::DEF_STG_ITER_NB,
  parameter int GRAM_NB      = acc_read_pkg::DEF_GRAM_NB,
  parameter int FIFO_DEPTH   = acc_read_pkg::DEF_FIFO_DEPTH,
  parameter int DATA_LATENCY = acc_read_pkg::DEF_DATA_LATENCY,
  parameter int ADD_W        = 8,
  parameter int MAP_IDX_W    = 4,
  localparam int GRID_W      = acc_read_pkg::cnt_w(GRAM_NB),
  localparam int CT_WORDS    = acc_read_pkg::ct_words(GLWE_K, STG_ITER_NB),
  localparam int GROF_W      = acc_read_pkg::grof_w(ADD_W, CT_WORDS)
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  // NTT core
  input  logic                 ntt_acc_avail,
  input  logic [DATA_W-1:0]    ntt_acc_data,
  input  logic                 ntt_acc_sog,
  input  logic                 ntt_acc_eog,
  // Command
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic [GRID_W-1:0]    cmd_grid,
  input  logic [GROF_W-1:0]    cmd_grof,
  input  logic                 cmd_first,
  input  logic                 cmd_last,
  input  logic                 cmd_batch_last,
  input  logic [MAP_IDX_W-1:0] cmd_map_idx,
  // GRAM arbiter
  output logic                 garb_req_vld,
  input  logic                 garb_req_rdy,
  output logic [GRID_W-1:0]    garb_req_grid,
  output logic                 garb_req_critical,
  input  logic [GRAM_NB-1:0]   garb_rd_avail_1h,
  // GRAM read and accumulate slot
  output logic                 rd_en,
  output logic [ADD_W-1:0]     rd_add,
  output logic [GRID_W-1:0]    rd_grid,
  output logic                 s0_mask_null,
  output logic                 s1_avail,
  output logic [ADD_W-1:0]     s1_add,
  output logic [GRID_W-1:0]    s1_grid,
  output logic [DATA_W-1:0]    s1_data,
  // Completion and status
  output logic                 feed_done,
  output logic [MAP_IDX_W-1:0] feed_done_map_idx,
  output logic                 br_loop_done,
  output logic                 sxt_avail,
  output logic [MAP_IDX_W-1:0] sxt_map_idx,
  output logic                 error
);

  // ====================
  // Parameter checks
  // ====================
  if (FIFO_DEPTH / CT_WORDS < 3) begin : g_bad_fifo_depth
    $fatal(1, "FIFO_DEPTH %0d holds fewer than 3 ciphertexts of %0d words",
           FIFO_DEPTH, CT_WORDS);
  end
  if ((STG_ITER_NB & (STG_ITER_NB - 1)) != 0) begin : g_bad_stg_iter
    $fatal(1, "STG_ITER_NB %0d is not a power of two", STG_ITER_NB);
  end

  logic                 new_ct_in;
  logic                 fifo_empty;
  logic [DATA_W-1:0]    head_data;
  logic                 head_eog;
  logic                 last_word;
  logic                 mask_null;
  logic [GRID_W-1:0]    cur_grid;
  logic [GROF_W-1:0]    cur_grof;
  logic                 cur_first;
  logic                 cur_last;
  logic                 cur_batch_last;
  logic [MAP_IDX_W-1:0] cur_map_idx;

  assign new_ct_in = ntt_acc_avail & ntt_acc_sog;
  assign rd_grid   = cur_grid;

  acc_infifo #(.DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) u_infifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .wr_en    (ntt_acc_avail),
    .wr_data  (ntt_acc_data),
    .wr_eog   (ntt_acc_eog),
    .rd_en    (rd_en),
    .head_data(head_data),
    .head_eog (head_eog),
    .empty    (fifo_empty),
    .error    (error)
  );

  acc_read_ctrl #(
    .GRAM_NB(GRAM_NB), .FIFO_DEPTH(FIFO_DEPTH), .GLWE_K(GLWE_K),
    .STG_ITER_NB(STG_ITER_NB), .ADD_W(ADD_W), .MAP_IDX_W(MAP_IDX_W)
  ) u_ctrl (
    .clk, .s_rst_n, .new_ct_in,
    .cmd_vld, .cmd_grid, .cmd_grof, .cmd_first, .cmd_last, .cmd_batch_last, .cmd_map_idx,
    .garb_req_rdy, .garb_rd_avail_1h, .fifo_empty, .last_word,
    .cmd_rdy, .garb_req_vld, .garb_req_grid, .garb_req_critical, .rd_en,
    .cur_grid, .cur_grof, .cur_first, .cur_last, .cur_batch_last, .cur_map_idx
  );

  acc_add_counter #(.GLWE_K(GLWE_K), .STG_ITER_NB(STG_ITER_NB), .ADD_W(ADD_W)) u_add_counter (
    .clk, .s_rst_n, .rd_en, .cur_grof, .cur_first, .rd_add, .last_word, .mask_null
  );

  acc_delay_line #(
    .DATA_W(DATA_W), .DATA_LATENCY(DATA_LATENCY), .ADD_W(ADD_W),
    .GRAM_NB(GRAM_NB), .MAP_IDX_W(MAP_IDX_W)
  ) u_delay_line (
    .clk, .s_rst_n, .rd_en, .rd_add, .cur_grid, .mask_null, .head_data, .head_eog,
    .cur_last, .cur_batch_last, .cur_map_idx,
    .s0_mask_null, .s1_avail, .s1_add, .s1_grid, .s1_data,
    .feed_done, .feed_done_map_idx, .br_loop_done, .sxt_avail, .sxt_map_idx
  );

endmodule

`default_nettype wire

// ==== hw/acc_delay_line.sv ====
`default_nettype none

module acc_delay_line #(
  parameter int DATA_W       = acc_read_pkg::DEF_DATA_W,
  parameter int DATA_LATENCY = acc_read_pkg::DEF_DATA_LATENCY,
  parameter int ADD_W        = 8,
  parameter int GRAM_NB      = acc_read_pkg::DEF_GRAM_NB,
  parameter int MAP_IDX_W    = 4,
  localparam int GRID_W      = acc_read_pkg::cnt_w(GRAM_NB)
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 rd_en,
  input  logic [ADD_W-1:0]     rd_add,
  input  logic [GRID_W-1:0]    cur_grid,
  input  logic                 mask_null,
  input  logic [DATA_W-1:0]    head_data,
  input  logic                 head_eog,
  input  logic                 cur_last,
  input  logic                 cur_batch_last,
  input  logic [MAP_IDX_W-1:0] cur_map_idx,
  output logic                 s0_mask_null,
  output logic                 s1_avail,
  output logic [ADD_W-1:0]     s1_add,
  output logic [GRID_W-1:0]    s1_grid,
  output logic [DATA_W-1:0]    s1_data,
  output logic                 feed_done,
  output logic [MAP_IDX_W-1:0] feed_done_map_idx,
  output logic                 br_loop_done,
  output logic                 sxt_avail,
  output logic [MAP_IDX_W-1:0] sxt_map_idx
);

  // RAM latency plus address and read-data pipes
  localparam int SR_DEPTH = DATA_LATENCY + 2;
  localparam int PAY_W    = ADD_W + GRID_W + DATA_W + MAP_IDX_W + 4;

  // Mask flag sits in bit 0 so it can be tapped one stage early
  logic [PAY_W-1:0]     pay_in;
  logic [PAY_W-1:0]     pay_sr [SR_DEPTH];
  logic [SR_DEPTH-1:0]  avail_sr;
  logic                 s1_eog;
  logic                 s1_last;
  logic                 s1_batch_last;
  logic [MAP_IDX_W-1:0] s1_map_idx;
  logic                 s1_done;

  assign pay_in = {rd_add, cur_grid, head_data, head_eog, cur_last, cur_batch_last,
                   cur_map_idx, mask_null};

  always_ff @(posedge clk) begin
    if (!s_rst_n)
      avail_sr <= '0;
    else
      avail_sr <= {avail_sr[SR_DEPTH-2:0], rd_en};
  end

  always_ff @(posedge clk) begin
    pay_sr[0] <= pay_in;
    for (int i = 1; i < SR_DEPTH; i++)
      pay_sr[i] <= pay_sr[i-1];
  end

  // ====================
  // S1 slot
  // ====================
  assign s1_avail     = avail_sr[SR_DEPTH-1];
  assign s0_mask_null = pay_sr[SR_DEPTH-2][0];
  assign {s1_add, s1_grid, s1_data, s1_eog, s1_last, s1_batch_last, s1_map_idx} =
    pay_sr[SR_DEPTH-1][PAY_W-1:1];

  // Ciphertext leaves the accumulator on its eog word
  assign s1_done = s1_avail & s1_eog;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      feed_done    <= 1'b0;
      sxt_avail    <= 1'b0;
      br_loop_done <= 1'b0;
    end else begin
      feed_done    <= s1_done & ~s1_last;
      sxt_avail    <= s1_done & s1_last;
      br_loop_done <= s1_done & s1_batch_last;
    end
  end

  always_ff @(posedge clk) begin
    feed_done_map_idx <= s1_map_idx;
    sxt_map_idx       <= s1_map_idx;
  end

endmodule

`default_nettype wire

// ==== hw/acc_add_counter.sv ====
`default_nettype none

module acc_add_counter #(
  parameter int GLWE_K      = acc_read_pkg::DEF_GLWE_K,
  parameter int STG_ITER_NB = acc_read_pkg::DEF_STG_ITER_NB,
  parameter int ADD_W       = 8,
  localparam int CT_WORDS   = acc_read_pkg::ct_words(GLWE_K, STG_ITER_NB),
  localparam int GROF_W     = acc_read_pkg::grof_w(ADD_W, CT_WORDS)
) (
  input  logic              clk,
  input  logic              s_rst_n,
  input  logic              rd_en,
  input  logic [GROF_W-1:0] cur_grof,
  input  logic              cur_first,
  output logic [ADD_W-1:0]  rd_add,
  output logic              last_word,
  output logic              mask_null
);

  localparam int GLWE_K_P1 = GLWE_K + 1;
  localparam int PID_W     = acc_read_pkg::cnt_w(GLWE_K_P1);
  localparam int STG_W     = acc_read_pkg::cnt_w(STG_ITER_NB);

  logic [PID_W-1:0] poly_id;
  logic [STG_W-1:0] stg_iter;
  logic             last_pid;
  logic             last_stg;

  assign last_pid  = poly_id == PID_W'(GLWE_K_P1 - 1);
  assign last_stg  = stg_iter == STG_W'(STG_ITER_NB - 1);
  assign last_word = last_pid & last_stg;

  // Poly id is the inner index
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      poly_id  <= '0;
      stg_iter <= '0;
    end else if (rd_en) begin
      poly_id <= last_pid ? '0 : poly_id + 1'b1;
      if (last_pid)
        stg_iter <= last_stg ? '0 : stg_iter + 1'b1;
    end
  end

  assign rd_add = ADD_W'(poly_id * STG_ITER_NB + stg_iter + cur_grof * CT_WORDS);

  // First iteration only loaded the body so mask polys read as zero
  assign mask_null = cur_first & (poly_id < GLWE_K);

  // Grof and first stay fixed while a ciphertext is partly read
  a_cmd_stable: assert property (@(posedge clk) disable iff (!s_rst_n)
    (poly_id != '0 || stg_iter != '0) |-> $stable(cur_grof) && $stable(cur_first))
    else $error("acc_add_counter: command changed inside a ciphertext");

endmodule

`default_nettype wire

// ==== hw/acc_read_ctrl.sv ====
`default_nettype none

module acc_read_ctrl #(
  parameter int GRAM_NB     = acc_read_pkg::DEF_GRAM_NB,
  parameter int FIFO_DEPTH  = acc_read_pkg::DEF_FIFO_DEPTH,
  parameter int GLWE_K      = acc_read_pkg::DEF_GLWE_K,
  parameter int STG_ITER_NB = acc_read_pkg::DEF_STG_ITER_NB,
  parameter int ADD_W       = 8,
  parameter int MAP_IDX_W   = 4,
  localparam int GRID_W     = acc_read_pkg::cnt_w(GRAM_NB),
  localparam int CT_WORDS   = acc_read_pkg::ct_words(GLWE_K, STG_ITER_NB),
  localparam int GROF_W     = acc_read_pkg::grof_w(ADD_W, CT_WORDS)
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 new_ct_in,
  input  logic                 cmd_vld,
  input  logic [GRID_W-1:0]    cmd_grid,
  input  logic [GROF_W-1:0]    cmd_grof,
  input  logic                 cmd_first,
  input  logic                 cmd_last,
  input  logic                 cmd_batch_last,
  input  logic [MAP_IDX_W-1:0] cmd_map_idx,
  input  logic                 garb_req_rdy,
  input  logic [GRAM_NB-1:0]   garb_rd_avail_1h,
  input  logic                 fifo_empty,
  input  logic                 last_word,
  output logic                 cmd_rdy,
  output logic                 garb_req_vld,
  output logic [GRID_W-1:0]    garb_req_grid,
  output logic                 garb_req_critical,
  output logic                 rd_en,
  output logic [GRID_W-1:0]    cur_grid,
  output logic [GROF_W-1:0]    cur_grof,
  output logic                 cur_first,
  output logic                 cur_last,
  output logic                 cur_batch_last,
  output logic [MAP_IDX_W-1:0] cur_map_idx
);

  // Half of the ciphertexts the FIFO can hold
  localparam int CT_THRES = (FIFO_DEPTH / CT_WORDS) / 2;
  localparam int PEND_W   = $clog2(FIFO_DEPTH + 1);

  acc_read_pkg::acc_state_e state;
  logic [1:0]               new_ct_dly;
  logic [PEND_W-1:0]        pend_cnt;
  logic                     cmd_take;

  // ====================
  // Pending ciphertexts
  // ====================
  // New ciphertexts are counted two cycles late so their first word is
  // already visible at the FIFO head
  assign cmd_take = cmd_vld & cmd_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      new_ct_dly <= '0;
      pend_cnt   <= '0;
    end else begin
      new_ct_dly <= {new_ct_dly[0], new_ct_in};
      if (new_ct_dly[1] && !cmd_take)
        pend_cnt <= pend_cnt + 1'b1;
      else if (!new_ct_dly[1] && cmd_take)
        pend_cnt <= pend_cnt - 1'b1;
    end
  end

  assign garb_req_critical = pend_cnt > PEND_W'(CT_THRES);

  // ====================
  // Command FSM
  // ====================
  assign cmd_rdy       = (state == acc_read_pkg::IDLE) && (pend_cnt != '0);
  assign garb_req_vld  = state == acc_read_pkg::REQ;
  assign garb_req_grid = cur_grid;
  assign rd_en         = (state == acc_read_pkg::READ) & garb_rd_avail_1h[cur_grid] & ~fifo_empty;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state <= acc_read_pkg::IDLE;
    end else begin
      case (state)
        acc_read_pkg::IDLE: if (cmd_take) state <= acc_read_pkg::REQ;
        acc_read_pkg::REQ:  if (garb_req_rdy) state <= acc_read_pkg::READ;
        acc_read_pkg::READ: if (rd_en && last_word) state <= acc_read_pkg::IDLE;
        default:            state <= acc_read_pkg::IDLE;
      endcase
    end
  end

  // Latched command held until the last word is read
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cur_grid       <= cmd_grid;
      cur_grof       <= cmd_grof;
      cur_first      <= cmd_first;
      cur_last       <= cmd_last;
      cur_batch_last <= cmd_batch_last;
      cur_map_idx    <= cmd_map_idx;
    end
  end

  // Arbiter only answers a pending request
  a_rdy_with_req: assert property (@(posedge clk) disable iff (!s_rst_n)
    garb_req_rdy |-> garb_req_vld)
    else $error("acc_read_ctrl: arbiter ready without request");

  // Arbiter grants at most one bank at a time
  a_grant_1h: assert property (@(posedge clk) disable iff (!s_rst_n)
    $onehot0(garb_rd_avail_1h))
    else $error("acc_read_ctrl: grant not one-hot");

endmodule

`default_nettype wire

// ==== hw/acc_infifo.sv ====
`default_nettype none

module acc_infifo #(
  parameter int DATA_W     = acc_read_pkg::DEF_DATA_W,
  parameter int FIFO_DEPTH = acc_read_pkg::DEF_FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              s_rst_n,
  input  logic              wr_en,
  input  logic [DATA_W-1:0] wr_data,
  input  logic              wr_eog,
  input  logic              rd_en,
  output logic [DATA_W-1:0] head_data,
  output logic              head_eog,
  output logic              empty,
  output logic              error
);

  localparam int PTR_W = acc_read_pkg::cnt_w(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Each entry holds {eog, data}
  logic [DATA_W:0]    mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   fill;
  logic               full;
  logic               push;
  logic               pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full  = fill == CNT_W'(FIFO_DEPTH);
  assign empty = fill == '0;
  assign push  = wr_en & ~full;
  assign pop   = rd_en & ~empty;

  // Show-ahead head
  assign {head_eog, head_data} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= {wr_eog, wr_data};
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      error  <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // No back-pressure upstream, a word into a full FIFO is lost
      error <= wr_en & full;
    end
  end

  // The controller must only pop buffered words
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!s_rst_n) rd_en |-> !empty)
    else $error("acc_infifo: pop while empty");

endmodule

`default_nettype wire

// ==== hw/acc_read_pkg.sv ====
`default_nettype none

package acc_read_pkg;

  // ====================
  // Controller state
  // ====================
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    READ
  } acc_state_e;

  // ====================
  // Default sizes
  // ====================
  parameter int DEF_DATA_W       = 32;
  parameter int DEF_GLWE_K       = 1;
  parameter int DEF_STG_ITER_NB  = 4;
  parameter int DEF_GRAM_NB      = 4;
  parameter int DEF_FIFO_DEPTH   = 32;
  parameter int DEF_DATA_LATENCY = 3;

  // Index width, never below one bit
  function automatic int cnt_w(input int n);
    return (n <= 1) ? 1 : $clog2(n);
  endfunction

  // Words per ciphertext, mask polys plus body
  function automatic int ct_words(input int glwe_k, input int stg_iter_nb);
    return (glwe_k + 1) * stg_iter_nb;
  endfunction

  // Ciphertext slot index inside one GRAM bank
  function automatic int grof_w(input int add_w, input int ct_nb_words);
    return cnt_w((2 ** add_w) / ct_nb_words);
  endfunction

endpackage

`default_nettype wire
